/* vlog.f */
hdl/mcr3_ctrl_pkg.sv
hdl/analog_ramp.sv
hdl/rpm_gearbox.sv
hdl/gear_toggle.sv
hdl/input_port_mapper.sv
hdl/board_io_apb.sv
hdl/mcr3_controls_top.sv
verif/tb_mcr3_controls.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MCR3 controls testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_mcr3_controls \
	-Mdir obj_dir -o tb_mcr3_controls
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mcr3_controls > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* verif/tb_mcr3_controls.sv */
// MCR3 controls testbench
module tb_mcr3_controls;
	timeunit 1ns;
	timeprecision 1ps;

	import mcr3_ctrl_pkg::*;

	// All tests together take well under 1500 cycles
	localparam int CYCLE_LIMIT = 5000;

	logic clk_sys = 1'b0;
	logic reset;
	logic [7:0] p1_ctrl;
	logic [7:0] p2_ctrl;
	logic [7:0] p3_ctrl;
	logic [2:0] coin;
	logic [1:0] start;
	logic service;
	logic [3:0] dip;
	logic [6:0] game_sel;
	logic vsync;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [PORT_W-1:0] pwdata;
	logic [PORT_W-1:0] prdata;
	logic [PORT_W-1:0] port5;
	logic [PORT_W-1:0] port6;
	logic pready;
	logic pslverr;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	integer seed = 32'h112b;
	logic [2:0] pd_gear_exp;

	mcr3_controls_top i_dut (
		.clk_sys(clk_sys), .reset(reset), .p1_ctrl(p1_ctrl), .p2_ctrl(p2_ctrl),
		.p3_ctrl(p3_ctrl), .coin(coin), .start(start), .service(service), .dip(dip),
		.game_sel(game_sel), .vsync(vsync), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .port5(port5), .port6(port6)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ====================
	// Reference mapping
	// ====================
	function automatic logic [7:0] stick_pattern(input logic [7:0] ctl);
		return {2'b00, ctl[CTL_FIRE_B], ctl[CTL_FIRE_A], ctl[CTL_LEFT], ctl[CTL_DOWN],
			ctl[CTL_RIGHT], ctl[CTL_UP]};
	endfunction

	function automatic logic [7:0] rampage_port(input int idx);
		case (idx)
			0: return ~{2'b00, service, 3'b000, coin[1], coin[0]};
			1: return ~stick_pattern(p1_ctrl);
			2: return ~stick_pattern(p2_ctrl);
			3: return ~{dip[3], 4'b0000, dip[2], dip[1], dip[0]};
			default: return ~stick_pattern(p3_ctrl);
		endcase
	endfunction

	function automatic logic [7:0] power_drive_port(input int idx);
		case (idx)
			0: return ~{2'b00, service, 2'b00, coin[2], coin[1], coin[0]};
			1: return ~{p2_ctrl[5], p2_ctrl[4], pd_gear_exp[1], p2_ctrl[6],
				p1_ctrl[5], p1_ctrl[4], pd_gear_exp[0], p1_ctrl[6]};
			2: return ~{4'b0000, p3_ctrl[5], p3_ctrl[4], pd_gear_exp[2], p3_ctrl[6]};
			3: return ~{dip[3], dip[2], dip[1], dip[0], 4'b0000};
			default: return 8'hFF;
		endcase
	endfunction

	// Gear lever position as the game reads it
	function automatic logic [3:0] gear_code(input int pos);
		case (pos)
			1: return 4'h5;
			2: return 4'h6;
			3: return 4'h1;
			4: return 4'h2;
			default: return 4'h0;
		endcase
	endfunction

	function automatic logic [ADDR_W-1:0] port_addr(input int idx);
		case (idx)
			0: return ADDR_IN0;
			1: return ADDR_IN1;
			2: return ADDR_IN2;
			3: return ADDR_IN3;
			default: return ADDR_IN4;
		endcase
	endfunction

	// ====================
	// Bus and stimulus tasks
	// ====================
	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data,
		input logic exp_err);
		int waits;
		@(posedge clk_sys);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		waits = 0;
		do begin
			@(negedge clk_sys);
			waits++;
		end while (pready !== 1'b1 && waits < 16);
		check_count++;
		if (pready !== 1'b1) begin
			error_count++;
			$display("APB write to %h never completed", addr);
		end else if (pslverr !== exp_err) begin
			error_count++;
			$display("Mismatch at %0t: pslverr expected %b, got %b", $time, exp_err, pslverr);
		end
		@(posedge clk_sys);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read_check(input logic [ADDR_W-1:0] addr, input string name,
		input logic [7:0] exp_data, input logic exp_err);
		int waits;
		@(posedge clk_sys);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk_sys);
		penable <= 1'b1;
		waits = 0;
		do begin
			@(negedge clk_sys);
			waits++;
		end while (pready !== 1'b1 && waits < 16);
		check_count++;
		if (pready !== 1'b1) begin
			error_count++;
			$display("APB read of %s never completed", name);
		end else begin
			if (prdata !== exp_data) begin
				error_count++;
				$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_data, prdata);
			end
			if (pslverr !== exp_err) begin
				error_count++;
				$display("Mismatch at %0t: pslverr expected %b, got %b", $time, exp_err, pslverr);
			end
		end
		@(posedge clk_sys);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		{p1_ctrl, p2_ctrl, p3_ctrl} <= '0;
		{coin, start, service, dip, vsync} <= '0;
		{psel, penable, pwrite} <= '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Presses the masked buttons for a few cycles, then releases them
	task automatic press_buttons(input logic [7:0] m1, input logic [7:0] m2,
		input logic [7:0] m3);
		@(posedge clk_sys);
		p1_ctrl <= p1_ctrl | m1;
		p2_ctrl <= p2_ctrl | m2;
		p3_ctrl <= p3_ctrl | m3;
		repeat (3) @(posedge clk_sys);
		p1_ctrl <= p1_ctrl & ~m1;
		p2_ctrl <= p2_ctrl & ~m2;
		p3_ctrl <= p3_ctrl & ~m3;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic vsync_pulses(input int count);
		repeat (count) begin
			@(posedge clk_sys);
			vsync <= 1'b1;
			@(posedge clk_sys);
			vsync <= 1'b0;
			@(posedge clk_sys);
		end
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic reset_defaults();
		game_sel <= 7'd9;
		@(negedge clk_sys);
		check_count++;
		if (prdata !== 8'h00 || pslverr !== 1'b0) begin
			error_count++;
			$display("Mismatch at %0t: idle prdata/pslverr expected 00/0, got %h/%b",
				$time, prdata, pslverr);
		end
		for (int i = 0; i < 5; i++) begin
			apb_read_check(port_addr(i), $sformatf("in%0d", i), 8'hFF, 1'b0);
		end
		apb_read_check(ADDR_OUT5, "out5", 8'h00, 1'b0);
		apb_read_check(ADDR_OUT6, "out6", 8'h00, 1'b0);
		apb_read_check(5'h1C, "unmapped read", 8'h00, 1'b1);
		apb_write(5'h1C, 8'hFF, 1'b1);
		apb_read_check(ADDR_OUT5, "out5", 8'h00, 1'b0);
		apb_read_check(ADDR_OUT6, "out6", 8'h00, 1'b0);
	endtask

	task automatic rampage_mapping();
		logic [31:0] r;
		game_sel <= GAME_RAMPAGE;
		repeat (20) begin
			r = $random(seed);
			@(posedge clk_sys);
			p1_ctrl <= r[7:0];
			p2_ctrl <= r[15:8];
			p3_ctrl <= r[23:16];
			coin <= r[26:24];
			service <= r[27];
			dip <= r[31:28];
			@(posedge clk_sys);
			for (int i = 0; i < 5; i++) begin
				apb_read_check(port_addr(i), $sformatf("in%0d", i), rampage_port(i), 1'b0);
			end
		end
	endtask

	task automatic power_drive_gears();
		apply_reset();
		game_sel <= GAME_POWERDRV;
		p1_ctrl <= 8'h50;
		p2_ctrl <= 8'h10;
		p3_ctrl <= 8'h20;
		coin <= 3'b101;
		service <= 1'b1;
		dip <= 4'hA;
		pd_gear_exp = 3'b000;
		press_buttons(8'h00, 8'h80, 8'h00);
		pd_gear_exp[1] = 1'b1;
		for (int i = 0; i < 5; i++) begin
			apb_read_check(port_addr(i), $sformatf("in%0d", i), power_drive_port(i), 1'b0);
		end
		press_buttons(8'h00, 8'h80, 8'h00);
		pd_gear_exp[1] = 1'b0;
		apb_read_check(ADDR_IN1, "in1", power_drive_port(1), 1'b0);
		// A held button toggles only once
		@(posedge clk_sys);
		p2_ctrl <= p2_ctrl | 8'h80;
		pd_gear_exp[1] = 1'b1;
		repeat (8) @(posedge clk_sys);
		apb_read_check(ADDR_IN1, "in1", power_drive_port(1), 1'b0);
		@(posedge clk_sys);
		p2_ctrl <= p2_ctrl & 8'h7F;
		apb_read_check(ADDR_IN1, "in1", power_drive_port(1), 1'b0);
	endtask

	task automatic max_rpm_gearbox();
		int pos1;
		int pos2;
		apply_reset();
		game_sel <= GAME_MAXRPM;
		coin <= 3'b001;
		service <= 1'b1;
		dip <= 4'b0001;
		pos1 = 0;
		pos2 = 0;
		repeat (6) begin
			press_buttons(8'h10, 8'h00, 8'h00);
			if (pos1 < 4) begin
				pos1++;
			end
		end
		apb_read_check(ADDR_IN2, "in2", ~{gear_code(pos1), gear_code(pos2)}, 1'b0);
		repeat (2) begin
			press_buttons(8'h20, 8'h00, 8'h00);
			if (pos1 > 0) begin
				pos1--;
			end
		end
		press_buttons(8'h00, 8'h10, 8'h00);
		pos2 = 1;
		apb_read_check(ADDR_IN2, "in2", ~{gear_code(pos1), gear_code(pos2)}, 1'b0);
		// Start one drops player 1 to neutral
		@(posedge clk_sys);
		start <= 2'b01;
		@(posedge clk_sys);
		start <= 2'b00;
		pos1 = 0;
		apb_read_check(ADDR_IN2, "in2", ~{gear_code(pos1), gear_code(pos2)}, 1'b0);
		// Start two held while in0 is read
		@(posedge clk_sys);
		start <= 2'b10;
		@(posedge clk_sys);
		apb_read_check(ADDR_IN0, "in0", ~{service, 3'b000, start[0], start[1], coin[0], coin[1]},
			1'b0);
		apb_read_check(ADDR_IN3, "in3", {7'h7F, ~dip[0]}, 1'b0);
	endtask

	task automatic max_rpm_adc();
		int steer;
		int gas;
		apply_reset();
		game_sel <= GAME_MAXRPM;
		steer = 128;
		gas = 0;
		apb_write(ADDR_OUT6, 8'h00, 1'b0);
		apb_write(ADDR_OUT5, 8'h06, 1'b0);
		apb_read_check(ADDR_IN1, "in1", ~steer[7:0], 1'b0);
		p1_ctrl <= 8'h08;
		vsync_pulses(5);
		steer = steer + 20;
		apb_read_check(ADDR_IN1, "in1", ~steer[7:0], 1'b0);
		apb_write(ADDR_OUT5, 8'h02, 1'b0);
		apb_read_check(ADDR_IN1, "in1", ~gas[7:0], 1'b0);
		// Channel stays on gas1 while out6 bit 5 is set
		apb_write(ADDR_OUT6, 8'h20, 1'b0);
		apb_write(ADDR_OUT5, 8'h06, 1'b0);
		apb_read_check(ADDR_OUT5, "out5", 8'h06, 1'b0);
		check_count++;
		if (port5 !== 8'h06 || port6 !== 8'h20) begin
			error_count++;
			$display("Mismatch at %0t: port5/port6 expected 06/20, got %h/%h", $time, port5, port6);
		end
		p1_ctrl <= 8'h05;
		vsync_pulses(40);
		steer = (steer > 160) ? steer - 160 : 0;
		gas = (gas + 160 > 255) ? 255 : gas + 160;
		apb_read_check(ADDR_IN1, "in1", ~gas[7:0], 1'b0);
		apb_write(ADDR_OUT6, 8'h00, 1'b0);
		apb_read_check(ADDR_IN1, "in1", ~steer[7:0], 1'b0);
	endtask

	initial begin
		reset = 1'b1;
		{p1_ctrl, p2_ctrl, p3_ctrl} = '0;
		{coin, start, service, dip, vsync} = '0;
		{psel, penable, pwrite} = '0;
		paddr = '0;
		pwdata = '0;
		game_sel = 7'd9;
		pd_gear_exp = '0;
		apply_reset();
		reset_defaults();
		rampage_mapping();
		power_drive_gears();
		max_rpm_gearbox();
		max_rpm_adc();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* hdl/mcr3_controls_top.sv */
// MCR3 player control front end
module mcr3_controls_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p1_ctrl,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p2_ctrl,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p3_ctrl,
	input  logic [2:0]                        coin,
	input  logic [1:0]                        start,
	input  logic                              service,
	input  logic [3:0]                        dip,
	input  logic [6:0]                        game_sel,
	input  logic                              vsync,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [mcr3_ctrl_pkg::ADDR_W-1:0]  paddr,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  pwdata,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  port5,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  port6
);

	import mcr3_ctrl_pkg::*;

	logic [PORT_W-1:0] gas1;
	logic [PORT_W-1:0] gas2;
	logic [PORT_W-1:0] steer1;
	logic [PORT_W-1:0] steer2;
	gear_code_t        rpm_gear1;
	gear_code_t        rpm_gear2;
	logic [2:0]        pd_gear;
	logic [PORT_W-1:0] in0;
	logic [PORT_W-1:0] in1;
	logic [PORT_W-1:0] in2;
	logic [PORT_W-1:0] in3;
	logic [PORT_W-1:0] in4;

	// ====================
	// Max RPM pedals and steering
	// ====================
	analog_ramp #(.RESET_LEVEL('0)) i_gas1 (
		.clk_sys(clk_sys), .reset(reset), .vsync(vsync),
		.inc(p1_ctrl[CTL_UP]), .dec(p1_ctrl[CTL_DOWN]), .value(gas1)
	);
	analog_ramp #(.RESET_LEVEL(RAMP_CENTER)) i_steer1 (
		.clk_sys(clk_sys), .reset(reset), .vsync(vsync),
		.inc(p1_ctrl[CTL_RIGHT]), .dec(p1_ctrl[CTL_LEFT]), .value(steer1)
	);
	analog_ramp #(.RESET_LEVEL('0)) i_gas2 (
		.clk_sys(clk_sys), .reset(reset), .vsync(vsync),
		.inc(p2_ctrl[CTL_UP]), .dec(p2_ctrl[CTL_DOWN]), .value(gas2)
	);
	analog_ramp #(.RESET_LEVEL(RAMP_CENTER)) i_steer2 (
		.clk_sys(clk_sys), .reset(reset), .vsync(vsync),
		.inc(p2_ctrl[CTL_RIGHT]), .dec(p2_ctrl[CTL_LEFT]), .value(steer2)
	);

	// Gearboxes, start buttons drop to neutral
	rpm_gearbox i_gearbox1 (
		.clk_sys(clk_sys), .reset(reset), .shift_up(p1_ctrl[CTL_FIRE_A]),
		.shift_down(p1_ctrl[CTL_FIRE_B]), .neutral(start[0]), .code(rpm_gear1)
	);
	rpm_gearbox i_gearbox2 (
		.clk_sys(clk_sys), .reset(reset), .shift_up(p2_ctrl[CTL_FIRE_A]),
		.shift_down(p2_ctrl[CTL_FIRE_B]), .neutral(start[1]), .code(rpm_gear2)
	);

	// Power Drive gear shifters
	gear_toggle i_gear_toggle (
		.clk_sys(clk_sys), .reset(reset),
		.press({p3_ctrl[CTL_FIRE_D], p2_ctrl[CTL_FIRE_D], p1_ctrl[CTL_FIRE_D]}),
		.gear(pd_gear)
	);

	// ====================
	// Ports and CPU bus
	// ====================
	input_port_mapper i_mapper (
		.clk_sys(clk_sys), .reset(reset), .game_sel(game_sel),
		.p1_ctrl(p1_ctrl), .p2_ctrl(p2_ctrl), .p3_ctrl(p3_ctrl),
		.coin(coin), .start(start), .service(service), .dip(dip),
		.pd_gear(pd_gear), .rpm_gear1(rpm_gear1), .rpm_gear2(rpm_gear2),
		.gas1(gas1), .gas2(gas2), .steer1(steer1), .steer2(steer2),
		.out5(port5), .out6(port6),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3), .in4(in4)
	);

	board_io_apb i_board_io (
		.clk_sys(clk_sys), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3), .in4(in4),
		.out5(port5), .out6(port6)
	);

endmodule

/* hdl/board_io_apb.sv */
// APB slave for board input and output ports
module board_io_apb (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [mcr3_ctrl_pkg::ADDR_W-1:0]  paddr,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  pwdata,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  in0,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  in1,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  in2,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  in3,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  in4,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  out5,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  out6
);

	import mcr3_ctrl_pkg::*;

	logic              access;
	logic              addr_hit;
	logic              sel_out5;
	logic              sel_out6;
	logic [PORT_W-1:0] rd_data;

	// No wait states
	assign pready = 1'b1;
	assign access = psel & penable;

	// ====================
	// Address decode
	// ====================
	always_comb begin
		addr_hit = 1'b1;
		sel_out5 = 1'b0;
		sel_out6 = 1'b0;
		rd_data  = '0;
		case (paddr)
			ADDR_IN0:  rd_data = in0;
			ADDR_IN1:  rd_data = in1;
			ADDR_IN2:  rd_data = in2;
			ADDR_IN3:  rd_data = in3;
			ADDR_IN4:  rd_data = in4;
			ADDR_OUT5: begin
				rd_data  = out5;
				sel_out5 = 1'b1;
			end
			ADDR_OUT6: begin
				rd_data  = out6;
				sel_out6 = 1'b1;
			end
			default:   addr_hit = 1'b0;
		endcase
	end

	assign prdata  = (access & ~pwrite) ? rd_data : '0;
	assign pslverr = access & ~addr_hit;

	// Output latches, written at the end of the access phase
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out5 <= '0;
			out6 <= '0;
		end else if (access & pwrite) begin
			if (sel_out5) begin
				out5 <= pwdata;
			end
			if (sel_out6) begin
				out6 <= pwdata;
			end
		end
	end

endmodule

/* hdl/input_port_mapper.sv */
// Per game input port assembly
module input_port_mapper (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [6:0]                        game_sel,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p1_ctrl,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p2_ctrl,
	input  logic [mcr3_ctrl_pkg::CTL_W-1:0]   p3_ctrl,
	input  logic [2:0]                        coin,
	input  logic [1:0]                        start,
	input  logic                              service,
	input  logic [3:0]                        dip,
	input  logic [2:0]                        pd_gear,
	input  mcr3_ctrl_pkg::gear_code_t         rpm_gear1,
	input  mcr3_ctrl_pkg::gear_code_t         rpm_gear2,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  gas1,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  gas2,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  steer1,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  steer2,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  out5,
	input  logic [mcr3_ctrl_pkg::PORT_W-1:0]  out6,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  in0,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  in1,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  in2,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  in3,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]  in4
);

	import mcr3_ctrl_pkg::*;

	logic [3:0]        adc_ctrl;
	logic [PORT_W-1:0] adc_byte;

	// Straight joystick layout used by Rampage
	function automatic logic [PORT_W-1:0] stick_byte(input logic [CTL_W-1:0] ctl);
		stick_byte = {2'b00, ctl[CTL_FIRE_B], ctl[CTL_FIRE_A], ctl[CTL_LEFT],
			ctl[CTL_DOWN], ctl[CTL_RIGHT], ctl[CTL_UP]};
	endfunction

	// ====================
	// Max RPM ADC channel
	// ====================
	// Channel follows out5 until out6 bits 6 and 5 freeze it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adc_ctrl <= '0;
		end else if (~out6[6] & ~out6[5]) begin
			adc_ctrl <= out5[4:1];
		end
	end

	always_comb begin
		case (adc_ctrl[1:0])
			2'd0: adc_byte = gas2;
			2'd1: adc_byte = gas1;
			2'd2: adc_byte = steer2;
			default: adc_byte = steer1;
		endcase
	end

	// ====================
	// Port assembly
	// ====================
	always_comb begin
		in0 = '1;
		in1 = '1;
		in2 = '1;
		in3 = '1;
		in4 = '1;
		case (game_sel)
			GAME_RAMPAGE: begin
				in0 = ~{2'b00, service, 3'b000, coin[1], coin[0]};
				in1 = ~stick_byte(p1_ctrl);
				in2 = ~stick_byte(p2_ctrl);
				in3 = ~{dip[3], 4'b0000, dip[2], dip[1], dip[0]};
				in4 = ~stick_byte(p3_ctrl);
			end
			GAME_POWERDRV: begin
				in0 = ~{2'b00, service, 2'b00, coin[2], coin[1], coin[0]};
				in1 = ~{p2_ctrl[CTL_FIRE_B], p2_ctrl[CTL_FIRE_A], pd_gear[1], p2_ctrl[CTL_FIRE_C],
					p1_ctrl[CTL_FIRE_B], p1_ctrl[CTL_FIRE_A], pd_gear[0], p1_ctrl[CTL_FIRE_C]};
				// Sound status bit tied inactive
				in2 = ~{4'b0000, p3_ctrl[CTL_FIRE_B], p3_ctrl[CTL_FIRE_A], pd_gear[2],
					p3_ctrl[CTL_FIRE_C]};
				in3 = ~{dip[3], dip[2], dip[1], dip[0], 4'b0000};
			end
			GAME_MAXRPM: begin
				in0 = ~{service, 3'b000, start[0], start[1], coin[0], coin[1]};
				in1 = ~adc_byte;
				in2 = ~{rpm_gear1, rpm_gear2};
				in3[0] = ~dip[0];
			end
			default: begin
			end
		endcase
	end

endmodule

/* hdl/gear_toggle.sv */
// Power Drive gear toggles
module gear_toggle (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [2:0] press,
	output logic [2:0] gear
);

	logic [2:0] press_last;
	logic [2:0] press_rise;

	// One toggle per press, holding the button does nothing
	assign press_rise = press & ~press_last;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			press_last <= '0;
			gear       <= '0;
		end else begin
			press_last <= press;
			gear       <= gear ^ press_rise;
		end
	end

endmodule

/* hdl/rpm_gearbox.sv */
// Max RPM five position gear lever
module rpm_gearbox (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      shift_up,
	input  logic                      shift_down,
	input  logic                      neutral,
	output mcr3_ctrl_pkg::gear_code_t code
);

	import mcr3_ctrl_pkg::*;

	gear_pos_t pos;
	logic      up_last;
	logic      down_last;
	logic      up_rise;
	logic      down_rise;

	assign up_rise   = shift_up & ~up_last;
	assign down_rise = shift_down & ~down_last;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pos       <= '0;
			up_last   <= 1'b0;
			down_last <= 1'b0;
		end else begin
			up_last   <= shift_up;
			down_last <= shift_down;
			if (neutral) begin
				pos <= '0;
			end else if (up_rise) begin
				// Up wins when both levers move together
				if (pos != GEAR_MAX) begin
					pos <= pos + 3'd1;
				end
			end else if (down_rise) begin
				if (pos != '0) begin
					pos <= pos - 3'd1;
				end
			end
		end
	end

	// Encoded lever position
	assign code = GEAR_CODES[pos];

endmodule

/* hdl/analog_ramp.sv */
// Frame stepped analog control value
module analog_ramp #(
	parameter logic [mcr3_ctrl_pkg::PORT_W-1:0] RESET_LEVEL = '0
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              vsync,
	input  logic                              inc,
	input  logic                              dec,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] value
);

	import mcr3_ctrl_pkg::*;

	logic              vsync_last;
	logic              frame_tick;
	logic [PORT_W:0]   up_sum;
	logic [PORT_W-1:0] up_value;
	logic [PORT_W-1:0] down_value;

	// Only the rising edge of the frame pulse moves the value
	assign frame_tick = vsync & ~vsync_last;

	// Saturating step in both directions
	assign up_sum     = {1'b0, value} + {1'b0, RAMP_STEP};
	assign up_value   = up_sum[PORT_W] ? '1 : up_sum[PORT_W-1:0];
	assign down_value = (value < RAMP_STEP) ? '0 : value - RAMP_STEP;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_last <= 1'b0;
			value      <= RESET_LEVEL;
		end else begin
			vsync_last <= vsync;
			if (frame_tick) begin
				// Increase has priority over decrease
				if (inc) begin
					value <= up_value;
				end else if (dec) begin
					value <= down_value;
				end
			end
		end
	end

endmodule

/* hdl/mcr3_ctrl_pkg.sv */
// MCR3 player control definitions
package mcr3_ctrl_pkg;

	// ====================
	// Game select codes
	// ====================
	localparam logic [6:0] GAME_RAMPAGE  = 7'd0;
	localparam logic [6:0] GAME_POWERDRV = 7'd2;
	localparam logic [6:0] GAME_MAXRPM   = 7'd3;

	// ====================
	// Player control byte
	// ====================
	localparam int unsigned CTL_W      = 8;
	localparam int unsigned CTL_UP     = 0;
	localparam int unsigned CTL_DOWN   = 1;
	localparam int unsigned CTL_LEFT   = 2;
	localparam int unsigned CTL_RIGHT  = 3;
	localparam int unsigned CTL_FIRE_A = 4;
	localparam int unsigned CTL_FIRE_B = 5;
	localparam int unsigned CTL_FIRE_C = 6;
	localparam int unsigned CTL_FIRE_D = 7;

	// ====================
	// Board ports and bus map
	// ====================
	localparam int unsigned PORT_W = 8;
	localparam int unsigned ADDR_W = 5;

	localparam logic [ADDR_W-1:0] ADDR_IN0  = 5'h00;
	localparam logic [ADDR_W-1:0] ADDR_IN1  = 5'h04;
	localparam logic [ADDR_W-1:0] ADDR_IN2  = 5'h08;
	localparam logic [ADDR_W-1:0] ADDR_IN3  = 5'h0C;
	localparam logic [ADDR_W-1:0] ADDR_IN4  = 5'h10;
	localparam logic [ADDR_W-1:0] ADDR_OUT5 = 5'h14;
	localparam logic [ADDR_W-1:0] ADDR_OUT6 = 5'h18;

	// ====================
	// Pedal and steering ramps
	// ====================
	localparam logic [PORT_W-1:0] RAMP_STEP   = 8'd4;
	localparam logic [PORT_W-1:0] RAMP_CENTER = 8'h80;

	// ====================
	// Max RPM gearbox
	// ====================
	localparam int unsigned GEAR_CODE_W = 4;

	typedef logic [2:0]             gear_pos_t;
	typedef logic [GEAR_CODE_W-1:0] gear_code_t;

	localparam gear_pos_t GEAR_MAX = 3'd4;

	// Lever position to the code the game expects
	localparam gear_code_t GEAR_CODES [0:4] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};

endpackage
